// ==== sim.f ====
src/isa_pkg.sv
src/mem_pkg.sv
src/store_lane.sv
src/load_format.sv
src/data_ram.sv
src/lsu_top.sv
testbench/lsu_chk.sv
testbench/tb_lsu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --timing --assert --timescale 1ns/1ps
TOP       := tb_lsu
RTL_TOP   := lsu_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
RTL_SRCS  := $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

# rtl alone, then the full bench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu
   import isa_pkg::*, mem_pkg::*;
();

   localparam int N_RAND = 24; // random sw/lw pairs in the tail
   localparam logic [ADDR_BITS-1:0] A_MIX = 17'h00100;              // width merge word
   localparam logic [ADDR_BITS-1:0] A_EXT = 17'h00200;              // sign/zero extension word
   localparam logic [ADDR_BITS-1:0] A_TOP = ADDR_BITS'(MEM_BYTES - 2); // straddles the wrap

   // one table row with expected fields filled by the model pass
   typedef struct packed {
      store_req_t      st;
      load_req_t       ld;
      logic [XLEN-1:0] exp_rd;
      logic            exp_load_err;
      logic            exp_store_err;
      logic            in_rst; // row applied with rst_n low
   } entry_t;

   logic            clk;
   logic            rst_n;
   store_req_t      st;
   load_req_t       ld;
   logic [XLEN-1:0] rd;
   logic            load_err;
   logic            store_err;

   entry_t     tbl [$];                 // stimulus table
   logic [7:0] model_mem [MEM_BYTES];   // reference byte array
   integer     seed;                    // $random state
   int         wd_cycles;               // watchdog budget in cycles
   bit         tbl_ready;               // set once the table is built
   store_req_t st_idle;                 // no store this cycle
   load_req_t  ld_idle;                 // no load this cycle

   lsu_top u_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .st        (st),
      .ld        (ld),
      .rd        (rd),
      .load_err  (load_err),
      .store_err (store_err)
   );

   bind lsu_top lsu_chk u_chk (
      .clk       (clk),
      .st        (st),
      .ld        (ld),
      .wr        (wr),
      .rd        (rd),
      .load_err  (load_err),
      .store_err (store_err)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk; // 100 ns period

   function automatic store_req_t st_req(input logic we, input logic [2:0] f3,
                                         input logic [ADDR_BITS-1:0] a,
                                         input logic [XLEN-1:0] d);
      store_req_t r;
      r.we   = we;
      r.op   = store_op_e'(f3); // raw code including illegal ones
      r.addr = a;
      r.data = d;
      return r;
   endfunction

   function automatic load_req_t ld_req(input logic re, input logic [2:0] f3,
                                        input logic [ADDR_BITS-1:0] a);
      load_req_t r;
      r.re   = re;
      r.op   = load_op_e'(f3);
      r.addr = a;
      return r;
   endfunction

   // bytes written by a store code or zero when illegal
   function automatic int store_bytes(input logic [2:0] f3);
      case (f3)
         3'b000:  return 1;
         3'b001:  return 2;
         3'b010:  return 4;
         default: return 0;
      endcase
   endfunction

   function automatic logic load_illegal(input logic [2:0] f3);
      return (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
   endfunction

   // expected rd from the model state
   function automatic logic [XLEN-1:0] model_load(input load_req_t l);
      logic [XLEN-1:0]      w;
      logic [ADDR_BITS-1:0] idx;
      logic [2:0]           f3;
      f3 = l.op;
      for (int i = 0; i < 4; i++) begin
         idx          = l.addr + ADDR_BITS'(i); // wraps modulo MEM_BYTES
         w[8*i +: 8] = model_mem[idx];
      end
      if (!l.re) return '0;
      case (f3)
         3'b000:  return {{24{w[7]}}, w[7:0]};   // lb
         3'b001:  return {{16{w[15]}}, w[15:0]}; // lh
         3'b010:  return w;                      // lw
         3'b100:  return {24'h0, w[7:0]};        // lbu
         3'b101:  return {16'h0, w[15:0]};       // lhu
         default: return '0;
      endcase
   endfunction

   task automatic add_entry(input store_req_t s, input load_req_t l, input logic in_rst);
      entry_t e;
      e        = '0;
      e.st     = s;
      e.ld     = l;
      e.in_rst = in_rst;
      tbl.push_back(e);
   endtask

   // walk the table once so loads see the state before the row's write edge
   task automatic compute_expected();
      entry_t               e;
      int                   n;
      logic [ADDR_BITS-1:0] idx;
      for (int k = 0; k < tbl.size(); k++) begin
         e               = tbl[k];
         e.exp_rd        = model_load(e.ld);
         e.exp_load_err  = e.ld.re && load_illegal(e.ld.op);
         n               = store_bytes(e.st.op);
         e.exp_store_err = e.st.we && (n == 0);
         if (e.st.we && !e.in_rst) begin
            for (int i = 0; i < n; i++) begin
               idx            = e.st.addr + ADDR_BITS'(i);
               model_mem[idx] = e.st.data[8*i +: 8];
            end
         end
         tbl[k] = e;
      end
   endtask

   task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED time %0t: %s expected %h actual %h", $time, name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED time %0t: %s expected %b actual %b", $time, name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic build_table();
      logic [ADDR_BITS-1:0] r_addr;
      logic [XLEN-1:0]      r_data;
      // sw then narrower overwrites
      add_entry(st_req(1'b1, SW, A_MIX, 32'h11223344), ld_idle, 1'b0);
      add_entry(st_req(1'b1, SB, A_MIX, 32'hFFFFFFAA), ld_idle, 1'b0);
      add_entry(st_req(1'b1, SH, A_MIX + 17'd1, 32'h1234BEEF), ld_req(1'b1, LW, A_MIX), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LW, A_MIX), 1'b0);
      // extension over bytes 80 7f 01 80
      add_entry(st_req(1'b1, SW, A_EXT, 32'h80017F80), ld_idle, 1'b0);
      add_entry(st_idle, ld_req(1'b1, LB, A_EXT), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LBU, A_EXT), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LB, A_EXT + 17'd1), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LBU, A_EXT + 17'd1), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LH, A_EXT), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LHU, A_EXT), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LH, A_EXT + 17'd2), 1'b0);  // 8001
      add_entry(st_idle, ld_req(1'b1, LHU, A_EXT + 17'd2), 1'b0);
      // read during write returns the old word then the new
      add_entry(st_req(1'b1, SW, A_MIX, 32'hCAFEF00D), ld_req(1'b1, LW, A_MIX), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LW, A_MIX), 1'b0);
      // wrap across the top of memory
      add_entry(st_req(1'b1, SW, 17'h0, 32'h55667788), ld_idle, 1'b0);
      add_entry(st_req(1'b1, SW, A_TOP, 32'hA1B2C3D4), ld_req(1'b1, LW, 17'h0), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LW, A_TOP), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LH, A_TOP + 17'd1), 1'b0);
      add_entry(st_idle, ld_req(1'b1, LW, 17'h0), 1'b0);
      // illegal codes
      add_entry(st_req(1'b1, 3'b011, A_MIX, 32'hDEADBEEF), ld_idle, 1'b0);
      add_entry(st_req(1'b1, 3'b111, A_MIX, 32'hDEADBEEF), ld_req(1'b1, LW, A_MIX), 1'b0);
      add_entry(st_req(1'b0, 3'b101, A_MIX, 32'hDEADBEEF), ld_req(1'b1, LW, A_MIX), 1'b0);
      add_entry(st_idle, ld_req(1'b1, 3'b011, A_MIX), 1'b0);
      add_entry(st_idle, ld_req(1'b1, 3'b110, A_MIX), 1'b0);
      add_entry(st_idle, ld_req(1'b1, 3'b111, A_MIX), 1'b0);
      add_entry(st_idle, ld_req(1'b0, LW, A_MIX), 1'b0);   // re low
      add_entry(st_idle, ld_req(1'b0, 3'b111, A_MIX), 1'b0); // re low with a bad code
      // stores under reset are dropped
      add_entry(st_req(1'b1, SW, A_MIX, 32'h0BAD0BAD), ld_req(1'b1, LW, A_MIX), 1'b1);
      add_entry(st_req(1'b1, SB, A_MIX + 17'd3, 32'h000000EE), ld_idle, 1'b1);
      add_entry(st_idle, ld_req(1'b1, LW, A_MIX), 1'b0);
      // random tail
      for (int p = 0; p < N_RAND; p++) begin
         r_addr = ADDR_BITS'($random(seed));
         r_data = $random(seed);
         add_entry(st_req(1'b1, SW, r_addr, r_data), ld_idle, 1'b0);
         add_entry(st_idle, ld_req(1'b1, LW, r_addr), 1'b0);
      end
   endtask

   initial begin
      seed    = 32'h01c1eea5;
      st_idle = st_req(1'b0, SB, 17'h0, 32'h0);
      ld_idle = ld_req(1'b0, LW, 17'h0);
      rst_n   = 1'b0;
      st      = st_idle;
      ld      = ld_idle;
      build_table();
      compute_expected();
      wd_cycles = tbl.size() + N_RAND + 20;
      tbl_ready = 1'b1;
      repeat (10) @(posedge clk);
      #5;
      rst_n = 1'b1;
      for (int k = 0; k < tbl.size(); k++) begin
         @(posedge clk);
         #5;
         rst_n = ~tbl[k].in_rst;
         st    = tbl[k].st;
         ld    = tbl[k].ld;
         @(negedge clk); // mid-cycle where combinational outputs have settled
         check_word($sformatf("rd (entry %0d)", k), tbl[k].exp_rd, rd);
         check_flag($sformatf("load_err (entry %0d)", k), tbl[k].exp_load_err, load_err);
         check_flag($sformatf("store_err (entry %0d)", k), tbl[k].exp_store_err, store_err);
      end
      $display("TEST OK");
      $finish;
   end

   // watchdog
   initial begin
      wait (tbl_ready);
      #(wd_cycles * 100);
      $display("run timed out after %0d cycles without finishing", wd_cycles);
      $display("TEST FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule : tb_lsu

`default_nettype wire

// ==== testbench/lsu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_chk
   import isa_pkg::*, mem_pkg::*;
(
   input wire logic            clk,
   input wire store_req_t      st,        // top-level store request
   input wire load_req_t       ld,        // top-level load request
   input wire ram_wr_t         wr,        // store_lane to ram
   input wire logic [XLEN-1:0] rd,
   input wire logic            load_err,
   input wire logic            store_err
);

   // illegal store writes nothing
   a_err_no_be: assert property (@(posedge clk) store_err |-> (wr.be == '0))
      else $error("store_err high with lane enables set");

   // result gated by re
   a_re_low_rd: assert property (@(posedge clk) !ld.re |-> (rd == '0))
      else $error("rd nonzero while re low");

   a_lerr_rd: assert property (@(posedge clk) load_err |-> (rd == '0))
      else $error("rd nonzero with load_err");

   // no lanes without the strobe
   a_we_low_be: assert property (@(posedge clk) !st.we |-> (wr.be == '0))
      else $error("lane enables set while we low");

endmodule : lsu_chk

`default_nettype wire

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
   import isa_pkg::*, mem_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  store_req_t      st,        // store request, we is a strobe
   input  load_req_t       ld,        // load request, re is a level
   output logic [XLEN-1:0] rd,        // load result, same cycle
   output logic            load_err,  // bad load funct3
   output logic            store_err  // bad store funct3
);

   ram_wr_t   wr;    // store path to ram
   ram_word_t rword; // ram to load path

   // store request to byte lanes
   store_lane u_store_lane (
      .st        (st),
      .wr        (wr),
      .store_err (store_err)
   );

   // byte array
   data_ram u_ram (
      .clk    (clk),
      .rst_n  (rst_n),
      .wr     (wr),
      .r_addr (ld.addr),
      .rword  (rword)
   );

   // select and extend the read bytes
   load_format u_load_format (
      .ld       (ld),
      .rword    (rword),
      .rd       (rd),
      .load_err (load_err)
   );

endmodule : lsu_top

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram
   import mem_pkg::*;
(
   input  wire logic                 clk,
   input  wire logic                 rst_n,  // writes blocked while low
   input  ram_wr_t                   wr,     // lane write port
   input  wire logic [ADDR_BITS-1:0] r_addr, // read base address
   output ram_word_t                 rword   // bytes r_addr .. r_addr+3
);

   logic [7:0] mem [MEM_BYTES]; // byte array, contents never cleared

   logic [ADDR_BITS-1:0] w_idx [BYTES_PER_WORD]; // per-lane write address
   logic [ADDR_BITS-1:0] r_idx [BYTES_PER_WORD]; // per-lane read address

   // lane addresses, 17-bit add wraps at the top of memory
   for (genvar g = 0; g < BYTES_PER_WORD; g++) begin : g_lane_addr
      assign w_idx[g] = wr.addr + ADDR_BITS'(g);
      assign r_idx[g] = r_addr + ADDR_BITS'(g);
   end

   // write port, one edge
   always_ff @(posedge clk) begin
      if (rst_n) begin
         for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (wr.be[i]) begin
               mem[w_idx[i]] <= wr.data[8*i +: 8]; // only enabled lanes
            end
         end
      end
   end

   // read port, asynchronous, no enable
   always_comb begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         rword[i] = mem[r_idx[i]]; // old data until the write edge
      end
   end

endmodule : data_ram

`default_nettype wire

// ==== src/load_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_format
   import isa_pkg::*, mem_pkg::*;
(
   input  load_req_t       ld,      // load request
   input  ram_word_t       rword,   // four bytes from the base address
   output logic [XLEN-1:0] rd,      // value for the register file
   output logic            load_err // illegal funct3 with re high
);

   logic [XLEN-1:0] result; // shaped value before the re gate
   logic            err;    // decode error before the re gate

   // width select and extension
   always_comb begin
      result = '0;
      err    = 1'b0;
      case (ld.op)
         LB: begin
            result = {{(XLEN-8){rword[0][7]}}, rword[0]}; // sign from bit 7
         end
         LBU: begin
            result = {{(XLEN-8){1'b0}}, rword[0]};
         end
         LH: begin
            result = {{(XLEN-16){rword[1][7]}}, rword[1], rword[0]}; // sign from bit 15
         end
         LHU: begin
            result = {{(XLEN-16){1'b0}}, rword[1], rword[0]};
         end
         LW: begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
               result[8*i +: 8] = rword[i]; // little endian assembly
            end
         end
         default: begin
            err = 1'b1; // 3'b011, 3'b110, 3'b111
         end
      endcase
   end

   // outputs only live while the load is requested
   always_comb begin
      if (ld.re) begin
         rd       = err ? '0 : result; // illegal op returns zero
         load_err = err;
      end else begin
         rd       = '0;
         load_err = 1'b0;
      end
   end

endmodule : load_format

`default_nettype wire

// ==== src/store_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_lane
   import isa_pkg::*, mem_pkg::*;
(
   input  store_req_t st,       // store request
   output ram_wr_t    wr,       // lane write to the ram
   output logic       store_err // illegal funct3 with we high
);

   logic [BYTES_PER_WORD-1:0] lane_mask; // lanes touched by this width
   logic                      legal;     // funct3 is sb, sh or sw

   // width decode
   always_comb begin
      lane_mask = '0;
      legal     = 1'b1;
      case (st.op)
         SB:      lane_mask = 4'b0001; // lane 0
         SH:      lane_mask = 4'b0011; // lanes 1:0
         SW:      lane_mask = 4'b1111; // whole word
         default: legal     = 1'b0;    // nothing written
      endcase
   end

   // lane data and enables
   always_comb begin
      wr.addr = st.addr; // base address unchanged, ram adds the lane offset
      wr.be   = (st.we && legal) ? lane_mask : '0;
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
         // low bytes of rs2 already line up with lane 0 upward
         wr.data[8*i +: 8] = lane_mask[i] ? st.data[8*i +: 8] : 8'h00; // unused lanes zero
      end
   end

   assign store_err = st.we & ~legal; // level, low whenever we is low

endmodule : store_lane

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;
   import isa_pkg::*;

   // memory geometry
   localparam int ADDR_BITS      = 17;             // byte address width
   localparam int MEM_BYTES      = 1 << ADDR_BITS; // 128 KiB of data ram
   localparam int BYTES_PER_WORD = 4;              // lanes per access

   // store request from the execute stage
   typedef struct packed {
      logic                 we;   // write strobe, one cycle
      store_op_e            op;   // funct3 of the store
      logic [ADDR_BITS-1:0] addr; // byte address, may be unaligned
      logic [XLEN-1:0]      data; // rs2 value
   } store_req_t;

   // load request, a level while the result is wanted
   typedef struct packed {
      logic                 re;   // result wanted
      load_op_e             op;   // funct3 of the load
      logic [ADDR_BITS-1:0] addr; // byte address, may be unaligned
   } load_req_t;

   // lane-level write into the ram
   typedef struct packed {
      logic [BYTES_PER_WORD-1:0] be;   // one enable per lane
      logic [ADDR_BITS-1:0]      addr; // base byte address
      logic [XLEN-1:0]           data; // lane 0 in bits 7:0
   } ram_wr_t;

   // four bytes read from the ram, index 0 = base address
   typedef logic [BYTES_PER_WORD-1:0][7:0] ram_word_t;

endpackage : mem_pkg

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // integer register width, rv32i
   localparam int XLEN = 32;

   // load funct3, bit 2 marks the unsigned variants
   typedef enum logic [2:0] {
      LB  = 3'b000, // byte, sign-extended
      LH  = 3'b001, // half, sign-extended
      LW  = 3'b010, // full word
      LBU = 3'b100, // byte, zero-extended
      LHU = 3'b101  // half, zero-extended
   } load_op_e;

   // store funct3, only the low two bits carry the width
   typedef enum logic [2:0] {
      SB = 3'b000, // one byte
      SH = 3'b001, // two bytes
      SW = 3'b010  // four bytes
   } store_op_e;

   // 3'b011, 3'b110, 3'b111 are illegal for loads
   // anything above 3'b010 is illegal for stores

endpackage : isa_pkg

`default_nettype wire
